// File: Bender.yml
package:
  name: uart_apb

sources:
  - include_dirs:
      - source
    files:
      - source/apb_pkg.sv
      - source/uart_pkg.sv
      - source/uart_tx_if.sv
      - source/uart_apb_regs.sv
      - source/uart_tx_fifo.sv
      - source/uart_tx_shift.sv
      - source/uart_apb_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - testbench/tb_uart_apb_top.sv

// File: source/apb_pkg.sv
// APB bus-side types for the UART register block
package apb_pkg;

    typedef logic [11:0] apb_addr_t;  // Register offset within the slave
    typedef logic [31:0] apb_data_t;  // Read and write data word

    // Register decode result
    typedef enum logic [1:0] {
        REG_TXDATA  = 2'd0,  // Transmit data
        REG_STATUS  = 2'd1,  // Status word
        REG_DIVISOR = 2'd2,  // Baud divisor
        REG_NONE    = 2'd3   // Unmapped offset
    } apb_reg_e;

endpackage

// File: source/uart_apb_regs.sv
// APB register slave: decodes offsets, pushes TX bytes, reports status, holds divisor
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_apb_regs (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  apb_pkg::apb_addr_t paddr,
    input  apb_pkg::apb_data_t pwdata,
    output apb_pkg::apb_data_t prdata,
    output logic               pready,
    output logic               pslverr,
    uart_tx_if.regs            tx
);

    apb_pkg::apb_reg_e   reg_sel;     // Decoded register
    apb_pkg::apb_data_t  status;      // Status word
    uart_pkg::uart_div_t divisor_q;   // Divisor register
    uart_pkg::uart_div_t wdiv;        // Divisor field of write data
    logic                access_wr;   // Write in access phase
    logic                err_txfull;  // Push into a full FIFO
    logic                err_div;     // Divisor below minimum
    logic                div_wr;      // Accepted divisor write

    // Offset decode
    always_comb begin
        case (paddr)
            `UART_ADDR_TXDATA:  reg_sel = apb_pkg::REG_TXDATA;
            `UART_ADDR_STATUS:  reg_sel = apb_pkg::REG_STATUS;
            `UART_ADDR_DIVISOR: reg_sel = apb_pkg::REG_DIVISOR;
            default:            reg_sel = apb_pkg::REG_NONE;
        endcase
    end

    assign access_wr  = psel & penable & pwrite;  // Takes effect at the closing edge
    assign wdiv       = pwdata[15:0];
    assign err_txfull = access_wr & (reg_sel == apb_pkg::REG_TXDATA) & tx.full;
    assign err_div    = access_wr & (reg_sel == apb_pkg::REG_DIVISOR)
                        & (wdiv < uart_pkg::uart_div_t'(`UART_DIV_MIN));
    assign div_wr     = access_wr & (reg_sel == apb_pkg::REG_DIVISOR) & ~err_div;

    assign pready  = 1'b1;  // Zero wait states
    assign pslverr = (psel & penable & (reg_sel == apb_pkg::REG_NONE))
                     | err_txfull | err_div;

    // Byte push, one edge per accepted write
    assign tx.wr_en   = access_wr & (reg_sel == apb_pkg::REG_TXDATA) & ~tx.full;
    assign tx.wr_data = pwdata[7:0];

    // Bit 0 busy, 1 full, 2 empty, 6:4 level
    assign status = {25'd0, tx.level, 1'b0, (tx.level == '0), tx.full, tx.busy};

    // Read mux, TXDATA reads as zero
    always_comb begin
        case (reg_sel)
            apb_pkg::REG_STATUS:  prdata = status;
            apb_pkg::REG_DIVISOR: prdata = {16'd0, divisor_q};
            default:              prdata = '0;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            divisor_q <= uart_pkg::uart_div_t'(`UART_DIV_RESET);
        end else if (div_wr) begin
            divisor_q <= wdiv;  // Serializer picks it up at next frame
        end
    end

    assign tx.divisor = divisor_q;

endmodule

// File: source/uart_apb_top.sv
// UART transmitter top: APB slave, byte FIFO and serializer on one serial output
`timescale 1ns/10ps

module uart_apb_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,     // APB select
    input  logic               penable,  // Access phase
    input  logic               pwrite,
    input  apb_pkg::apb_addr_t paddr,
    input  apb_pkg::apb_data_t pwdata,
    output apb_pkg::apb_data_t prdata,
    output logic               pready,   // Tied high inside
    output logic               pslverr,
    output logic               ser_out   // RS232 line
);

    uart_tx_if u_tx_if ();  // Internal byte stream and status

    // Bus side
    uart_apb_regs u_regs (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .tx      (u_tx_if.regs)
    );

    // Byte queue
    uart_tx_fifo u_fifo (
        .clk   (clk),
        .reset (reset),
        .tx    (u_tx_if.fifo)
    );

    // Line side
    uart_tx_shift u_shift (
        .clk     (clk),
        .reset   (reset),
        .tx      (u_tx_if.shift),
        .ser_out (ser_out)
    );

endmodule

// File: source/uart_consts.svh
// UART transmitter constants: FIFO sizing, APB register offsets and divisor limits
`ifndef UART_CONSTS_SVH
`define UART_CONSTS_SVH

// Transmit FIFO, depth must stay a power of two
`define UART_FIFO_DEPTH 4          // Byte slots
`define UART_FIFO_AW    2          // Pointer width, log2 of depth

// APB register map, byte offsets
`define UART_ADDR_TXDATA  12'h000  // Write pushes a byte
`define UART_ADDR_STATUS  12'h004  // Busy, full, empty, level
`define UART_ADDR_DIVISOR 12'h008  // Clk cycles per bit

// Baud divisor
`define UART_DIV_RESET 16          // Value after reset
`define UART_DIV_MIN   2           // Smallest accepted divisor

`endif

// File: source/uart_pkg.sv
// Serial line-side types for the UART transmit path
package uart_pkg;

    typedef logic [7:0]  uart_byte_t;   // Payload byte
    typedef logic [15:0] uart_div_t;    // Clk cycles per bit
    typedef logic [2:0]  uart_level_t;  // FIFO occupancy, 0 to 4

    // Serializer FSM
    typedef enum logic {
        TX_IDLE  = 1'b0,  // Line high, ready for a byte
        TX_SHIFT = 1'b1   // Frame on the line
    } tx_state_e;

endpackage

// File: source/uart_tx_fifo.sv
// Transmit byte FIFO with push, pop, full, empty and occupancy level
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_tx_fifo (
    input  logic    clk,
    input  logic    reset,
    uart_tx_if.fifo tx
);

    uart_pkg::uart_byte_t  mem [0:`UART_FIFO_DEPTH-1];  // Byte storage
    logic [`UART_FIFO_AW-1:0] wr_ptr;                   // Next free slot
    logic [`UART_FIFO_AW-1:0] rd_ptr;                   // Head entry
    uart_pkg::uart_level_t count;                       // Occupancy
    logic                  push;
    logic                  pop;

    assign pop  = tx.rd_valid & tx.rd_ready;  // Handshake with serializer
    assign push = tx.wr_en & (~tx.full | pop); // Full is fine if a slot frees now

    assign tx.full     = (count == uart_pkg::uart_level_t'(`UART_FIFO_DEPTH));
    assign tx.level    = count;
    assign tx.rd_valid = (count != '0);
    assign tx.rd_data  = mem[rd_ptr];  // Head shown without a read strobe

    // Byte storage written on push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= tx.wr_data;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;  // Wraps since depth is a power of two
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or push with pop
            endcase
        end
    end

endmodule

// File: source/uart_tx_if.sv
// Transmit path bundle linking the register block, byte FIFO and serializer
`timescale 1ns/10ps

interface uart_tx_if;

    uart_pkg::uart_byte_t  wr_data;   // Byte pushed by the register block
    logic                  wr_en;     // Push strobe
    logic                  full;      // FIFO has no free slot
    uart_pkg::uart_level_t level;     // FIFO occupancy
    uart_pkg::uart_byte_t  rd_data;   // Head entry of the FIFO
    logic                  rd_valid;  // FIFO not empty
    logic                  rd_ready;  // Serializer idle
    logic                  busy;      // Frame in progress
    uart_pkg::uart_div_t   divisor;   // Programmed bit time

    // APB register block
    modport regs (output wr_data, wr_en, divisor,
                  input  full, level, busy);

    // Byte FIFO
    modport fifo (input  wr_data, wr_en, rd_ready,
                  output full, level, rd_data, rd_valid);

    // Serializer
    modport shift (input  rd_data, rd_valid, divisor,
                   output rd_ready, busy);

endinterface

// File: source/uart_tx_shift.sv
// UART serializer: sends start, eight data bits LSB first and stop at a set bit time
`timescale 1ns/10ps
`include "uart_consts.svh"

module uart_tx_shift (
    input  logic     clk,
    input  logic     reset,
    uart_tx_if.shift tx,
    output logic     ser_out
);

    uart_pkg::tx_state_e state;    // FSM state
    logic [8:0]          rshift;   // Byte and start bit, ones shift in
    uart_pkg::uart_div_t div_lat;  // Bit time for this frame
    uart_pkg::uart_div_t cyc_cnt;  // Clk cycles into current bit
    logic [3:0]          bit_cnt;  // Bits completed in frame
    logic                take;     // Byte handed over
    logic                bit_end;  // Last cycle of a bit

    assign tx.rd_ready = (state == uart_pkg::TX_IDLE);
    assign tx.busy     = (state == uart_pkg::TX_SHIFT);
    assign take        = tx.rd_valid & tx.rd_ready;
    assign bit_end     = (cyc_cnt == div_lat - 1'b1);

    assign ser_out = rshift[0];  // Line idles high

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state   <= uart_pkg::TX_IDLE;
            rshift  <= '1;
            div_lat <= uart_pkg::uart_div_t'(`UART_DIV_RESET);
            cyc_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (take) begin
                        rshift  <= {tx.rd_data, 1'b0};  // Start bit goes out now
                        div_lat <= tx.divisor;          // Held for the whole frame
                        cyc_cnt <= '0;
                        bit_cnt <= '0;
                        state   <= uart_pkg::TX_SHIFT;
                    end
                end
                uart_pkg::TX_SHIFT: begin
                    if (bit_end) begin
                        cyc_cnt <= '0;
                        rshift  <= {1'b1, rshift[8:1]};  // Next bit, stop bit last
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 4'd9) begin
                            // Stop bit done, line stays high
                            state <= uart_pkg::TX_IDLE;
                        end
                    end else begin
                        cyc_cnt <= cyc_cnt + 1'b1;
                    end
                end
                default: begin
                    state <= uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

endmodule

// File: testbench/tb_uart_apb_top.sv
// Testbench for the APB UART transmitter with bus tasks, serial line decoder and checks
`timescale 1ns/10ps
`include "uart_consts.svh"

module tb_uart_apb_top;

    localparam int CLK_PERIOD = 20;
    localparam int RX_LIMIT   = 20000;  // Cycles allowed for frames to appear
    localparam int POLL_LIMIT = 2000;   // STATUS reads before giving up

    logic               clk;
    logic               reset;
    logic               psel;
    logic               penable;
    logic               pwrite;
    apb_pkg::apb_addr_t paddr;
    apb_pkg::apb_data_t pwdata;
    apb_pkg::apb_data_t prdata;
    logic               pready;
    logic               pslverr;
    logic               ser_out;

    integer     seed   = 3;                  // $random seed
    int         errors = 0;
    int         checks = 0;
    int         tb_div = `UART_DIV_RESET;    // Bit time the decoder uses
    int         starts = 0;                  // Start bits seen on the line
    logic [7:0] rx_q [$];                    // Decoded bytes
    logic [7:0] exp_q [$];                   // Bytes expected on the line

    uart_apb_top u_dut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .ser_out (ser_out)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic check_eq(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
        checks++;
        assert (got === exp)
        else begin
            $display("ERROR %0t %s got %0h expected %0h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic apb_write(input apb_pkg::apb_addr_t addr, input apb_pkg::apb_data_t data,
                             output logic err);
        @(negedge clk);
        psel    = 1'b1;  // Setup phase
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(negedge clk);
        penable = 1'b1;  // Access phase until the next rising edge
        #(CLK_PERIOD / 4);
        err = pslverr;
        check_eq("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_read(input apb_pkg::apb_addr_t addr, output apb_pkg::apb_data_t data,
                            output logic err);
        @(negedge clk);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(negedge clk);
        penable = 1'b1;
        #(CLK_PERIOD / 4);  // Read data settles combinationally
        data = prdata;
        err  = pslverr;
        check_eq("pready", pready, 1'b1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic wait_starts(input int n);
        int cyc;
        cyc = 0;
        while (starts < n && cyc < RX_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (starts < n) begin
            $display("Timeout: only %0d of %0d start bits seen on ser_out", starts, n);
            errors++;
        end
    endtask

    task automatic wait_rx(input int n);
        int cyc;
        cyc = 0;
        while (rx_q.size() < n && cyc < RX_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (rx_q.size() < n) begin
            $display("Timeout: only %0d of %0d bytes decoded from ser_out", rx_q.size(), n);
            errors++;
        end
    endtask

    task automatic wait_idle();
        apb_pkg::apb_data_t st;
        logic               err;
        int                 polls;
        polls = 0;
        st    = '1;
        while ((st[0] || !st[2]) && polls < POLL_LIMIT) begin  // Busy or FIFO not empty
            apb_read(`UART_ADDR_STATUS, st, err);
            polls++;
        end
        if (st[0] || !st[2]) begin
            $display("Timeout: transmitter never went idle with an empty FIFO");
            errors++;
        end
    endtask

    task automatic compare_rx();
        check_eq("rx byte count", rx_q.size(), exp_q.size());
        while (rx_q.size() > 0 && exp_q.size() > 0) begin
            check_eq("ser_out byte", rx_q.pop_front(), exp_q.pop_front());  // Write order
        end
        rx_q.delete();
        exp_q.delete();
    endtask

    task automatic report_test(input string name, input int base);
        $display("Test %0s: %0s, %0d errors", name, (errors == base) ? "ok" : "failed",
                 errors - base);
    endtask

    // Serial decoder sampling mid-bit on falling clk edges
    initial begin : line_decoder
        logic [7:0] data;
        int         div;
        forever begin
            @(negedge clk);
            if (reset === 1'b0 && ser_out === 1'b0) begin
                div = tb_div;  // Bit time fixed for this frame
                starts++;
                repeat (div / 2) @(negedge clk);
                check_eq("ser_out start bit", ser_out, 1'b0);
                for (int i = 0; i < 8; i++) begin
                    repeat (div) @(negedge clk);
                    data[i] = ser_out;  // LSB first
                end
                repeat (div) @(negedge clk);
                check_eq("ser_out stop bit", ser_out, 1'b1);
                rx_q.push_back(data);
            end
        end
    end

    initial begin : stimulus
        logic               err;
        apb_pkg::apb_data_t rd;
        logic [7:0]         b;
        int                 base;
        int                 accepted;
        int                 start_base;
        int                 level;
        reset   = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (10) @(negedge clk);
        reset = 1'b0;

        base = errors;
        check_eq("ser_out", ser_out, 1'b1);
        apb_read(`UART_ADDR_STATUS, rd, err);
        check_eq("status", rd, 32'h4);  // Empty only
        apb_read(`UART_ADDR_DIVISOR, rd, err);
        check_eq("divisor", rd, 16);
        report_test("reset state", base);

        base = errors;
        apb_write(`UART_ADDR_DIVISOR, 5, err);
        check_eq("pslverr", err, 1'b0);
        tb_div = 5;
        apb_read(`UART_ADDR_DIVISOR, rd, err);
        check_eq("divisor", rd, 5);
        b = $random(seed);
        exp_q.push_back(b);
        start_base = starts;
        apb_write(`UART_ADDR_TXDATA, b, err);
        check_eq("pslverr", err, 1'b0);
        wait_starts(start_base + 1);
        apb_read(`UART_ADDR_STATUS, rd, err);
        check_eq("status.busy", rd[0], 1'b1);  // Mid frame
        wait_rx(1);
        wait_idle();
        compare_rx();
        report_test("single frame", base);

        base = errors;
        for (int i = 0; i < 4; i++) begin
            b = $random(seed);
            exp_q.push_back(b);
            apb_write(`UART_ADDR_TXDATA, b, err);
            check_eq("pslverr", err, 1'b0);
            apb_read(`UART_ADDR_STATUS, rd, err);
            checks++;
            assert (rd[6:4] <= 4)
            else begin
                $display("ERROR %0t status.level got %0d expected at most 4", $time, rd[6:4]);
                errors++;
            end
        end
        wait_rx(4);
        wait_idle();
        compare_rx();
        report_test("burst order", base);

        base = errors;
        apb_write(`UART_ADDR_DIVISOR, 40, err);
        check_eq("pslverr", err, 1'b0);
        tb_div     = 40;
        accepted   = 0;
        start_base = starts;
        for (int i = 0; i < 6; i++) begin
            b = $random(seed);
            apb_write(`UART_ADDR_TXDATA, b, err);
            level = accepted - (starts - start_base);  // Queue depth when the write landed
            check_eq("pslverr", err, level == 4);
            if (level < 4) begin
                accepted++;
                exp_q.push_back(b);
            end
        end
        wait_rx(accepted);
        wait_idle();
        compare_rx();
        report_test("overflow", base);

        base = errors;
        apb_read(12'h00C, rd, err);
        check_eq("pslverr", err, 1'b1);  // Unmapped offset
        apb_write(12'h00C, 32'hFF, err);
        check_eq("pslverr", err, 1'b1);
        apb_write(`UART_ADDR_DIVISOR, 1, err);
        check_eq("pslverr", err, 1'b1);  // Below minimum
        apb_read(`UART_ADDR_DIVISOR, rd, err);
        check_eq("divisor", rd, 40);
        apb_read(`UART_ADDR_TXDATA, rd, err);
        check_eq("txdata", rd, 0);
        check_eq("pslverr", err, 1'b0);
        report_test("bus errors", base);

        base = errors;
        apb_write(`UART_ADDR_DIVISOR, 8, err);
        tb_div     = 8;
        start_base = starts;
        for (int i = 0; i < 2; i++) begin
            b = $random(seed);
            exp_q.push_back(b);
            apb_write(`UART_ADDR_TXDATA, b, err);
            check_eq("pslverr", err, 1'b0);
        end
        wait_starts(start_base + 1);
        apb_write(`UART_ADDR_DIVISOR, 12, err);  // First frame still at 8
        check_eq("pslverr", err, 1'b0);
        tb_div = 12;
        apb_read(`UART_ADDR_STATUS, rd, err);
        check_eq("status.busy", rd[0], 1'b1);
        wait_rx(2);
        wait_idle();
        compare_rx();
        report_test("divisor change", base);

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// File: uart_apb.f
+incdir+source
source/apb_pkg.sv
source/uart_pkg.sv
source/uart_tx_if.sv
source/uart_apb_regs.sv
source/uart_tx_fifo.sv
source/uart_tx_shift.sv
source/uart_apb_top.sv
testbench/tb_uart_apb_top.sv
